/* design/exu_pkg.sv */
package exu_pkg;

  // data memory geometry
  localparam int RAM_WORDS = 256;
  localparam int RAM_IDX_W = $clog2(RAM_WORDS);

  typedef logic [31:0] word_t;
  typedef logic [63:0] dword_t;
  typedef logic [7:0] strb_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [2:0] alu_funct_t;
  typedef logic [3:0] ls_t;
  typedef logic [2:0] goto_t;
  typedef logic [1:0] csrw_t;
  typedef logic [RAM_IDX_W-1:0] ram_idx_t;

  // alu function codes, rv32 funct3 meaning
  localparam alu_funct_t FN_ADD = 3'b000;
  localparam alu_funct_t FN_SLL = 3'b001;
  localparam alu_funct_t FN_SLT = 3'b010;
  localparam alu_funct_t FN_SLTU = 3'b011;
  localparam alu_funct_t FN_XOR = 3'b100;
  localparam alu_funct_t FN_SR = 3'b101;
  localparam alu_funct_t FN_OR = 3'b110;
  localparam alu_funct_t FN_AND = 3'b111;

  // access size in ls[1:0]
  localparam logic [1:0] LS_BYTE = 2'b00;
  localparam logic [1:0] LS_HALF = 2'b01;
  localparam logic [1:0] LS_WORD = 2'b10;

  localparam goto_t GOTO_NONE = 3'b000;
  localparam goto_t GOTO_PC_REL = 3'b001;
  localparam goto_t GOTO_REG_REL = 3'b010;
  localparam goto_t GOTO_REG = 3'b011;
  localparam goto_t GOTO_BNEZ = 3'b100;
  localparam goto_t GOTO_BEQZ = 3'b101;

  localparam csrw_t CSRW_NONE = 2'b00;
  localparam csrw_t CSRW_ALU = 2'b01;
  localparam csrw_t CSRW_VAL_B = 2'b10;
  // ebreak shows up as a write to csr 0
  localparam csrw_t CSRW_BREAK = 2'b11;

  typedef enum logic [2:0] {
    idle,
    hold,
    load_req,
    load_resp,
    store_req,
    store_addr,
    store_data,
    store_resp
  } exu_state_t;

  typedef struct packed {
    word_t pc;
    word_t val_a;
    word_t val_b;
    word_t val_c;
    logic alu_src;
    alu_funct_t alu_funct;
    logic alu_sw;
    reg_addr_t rd;
    logic rd_src;
    ls_t ls;
    goto_t goto;
    csrw_t csrw;
  } issue_t;

  typedef struct packed {
    logic gpr_wen;
    reg_addr_t gpr_waddr;
    word_t gpr_wdata;
    logic csr_wen;
    csr_addr_t csr_waddr;
    word_t csr_wdata;
  } wb_t;

  typedef struct packed {
    logic arvalid;
    word_t araddr;
    logic [2:0] arsize;
    logic rready;
    logic awvalid;
    word_t awaddr;
    logic [2:0] awsize;
    logic wvalid;
    dword_t wdata;
    strb_t wstrb;
    logic bready;
  } mem_req_t;

  typedef struct packed {
    logic arready;
    logic rvalid;
    dword_t rdata;
    logic awready;
    logic wready;
    logic bvalid;
  } mem_resp_t;

endpackage

/* design/alu.sv */
`timescale 1ns/1ns

module alu
  import exu_pkg::*;
(
  input  word_t      a,
  input  word_t      b,
  input  alu_funct_t funct,
  input  logic       sw,
  output word_t      result
);

  logic [4:0] shamt;
  word_t sum;
  word_t shift_r;

  assign shamt = b[4:0];

  // sw turns add into subtract
  assign sum = sw ? (a - b) : (a + b);

  always_comb begin
    if (sw) begin
      shift_r = word_t'($signed(a) >>> shamt);
    end else begin
      shift_r = a >> shamt;
    end
  end

  always_comb begin
    case (funct)
      FN_ADD: result = sum;
      FN_SLL: result = a << shamt;
      FN_SLT: result = {31'b0, $signed(a) < $signed(b)};
      FN_SLTU: result = {31'b0, a < b};
      FN_XOR: result = a ^ b;
      FN_SR: result = shift_r;
      FN_OR: result = a | b;
      FN_AND: result = a & b;
      default: result = '0;
    endcase
  end

endmodule

/* design/mem_align.sv */
`timescale 1ns/1ns

module mem_align
  import exu_pkg::*;
(
  input  ls_t        ls,
  input  logic [2:0] offset,
  input  word_t      store_val,
  input  dword_t     rdata,
  output dword_t     wdata,
  output strb_t      wstrb,
  output word_t      load_val
);

  logic [5:0] bit_shift;
  strb_t base_strb;
  dword_t rdata_shifted;
  logic sign_ext;

  // byte offset to bit offset
  assign bit_shift = {offset, 3'b000};
  assign sign_ext = ls[2];

  always_comb begin
    case (ls[1:0])
      LS_BYTE: base_strb = 8'h01;
      LS_HALF: base_strb = 8'h03;
      LS_WORD: base_strb = 8'h0f;
      default: base_strb = 8'h00;
    endcase
  end

  // store side, move data and strobe into the addressed lanes
  assign wdata = {32'b0, store_val} << bit_shift;
  assign wstrb = base_strb << offset;

  // load side, bring the addressed lane down to bit 0
  assign rdata_shifted = rdata >> bit_shift;

  always_comb begin
    case (ls[1:0])
      LS_BYTE: begin
        load_val = {{24{rdata_shifted[7] & sign_ext}}, rdata_shifted[7:0]};
      end
      LS_HALF: begin
        load_val = {{16{rdata_shifted[15] & sign_ext}}, rdata_shifted[15:0]};
      end
      default: begin
        load_val = rdata_shifted[31:0];
      end
    endcase
  end

endmodule

/* design/exu.sv */
`timescale 1ns/1ns

module exu
  import exu_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  issue_t    issue,
  input  logic      issue_valid,
  output logic      issue_ready,
  output wb_t       result,
  output logic      result_valid,
  input  logic      result_ready,
  output logic      jump_en,
  output word_t     jump_dnpc,
  output mem_req_t  mem_req,
  input  mem_resp_t mem_resp
);

  exu_state_t state;
  exu_state_t state_next;
  issue_t ins;
  word_t load_val_q;

  word_t alu_a;
  word_t alu_res;
  dword_t st_wdata;
  strb_t st_wstrb;
  word_t ld_val;

  logic issue_fire;
  logic take;
  word_t dnpc_base;
  word_t dnpc_offs;
  word_t dnpc;

  assign issue_ready = (state == idle) | ((state == hold) & result_ready);
  assign issue_fire = issue_valid & issue_ready;
  assign result_valid = (state == hold);

  always_comb begin
    state_next = state;
    case (state)
      hold: begin
        if (result_ready) state_next = idle;
      end
      load_req: begin
        if (mem_resp.arready) state_next = load_resp;
      end
      load_resp: begin
        if (mem_resp.rvalid) state_next = hold;
      end
      store_req: begin
        if (mem_resp.awready & mem_resp.wready) begin
          state_next = store_resp;
        end else if (mem_resp.awready) begin
          state_next = store_data;
        end else if (mem_resp.wready) begin
          state_next = store_addr;
        end
      end
      store_addr: begin
        if (mem_resp.awready) state_next = store_resp;
      end
      store_data: begin
        if (mem_resp.wready) state_next = store_resp;
      end
      store_resp: begin
        if (mem_resp.bvalid) state_next = hold;
      end
      default: ;
    endcase
    // a new instruction overrides the return to idle
    if (issue_fire) begin
      if (issue.ls == '0) begin
        state_next = hold;
      end else if (issue.ls[3]) begin
        state_next = load_req;
      end else begin
        state_next = store_req;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= idle;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clock) begin
    if (issue_fire) ins <= issue;
    if ((state == load_resp) & mem_resp.rvalid) load_val_q <= ld_val;
  end

  assign alu_a = ins.alu_src ? ins.pc : ins.val_a;

  alu u_alu (
    .a      (alu_a),
    .b      (ins.val_b),
    .funct  (ins.alu_funct),
    .sw     (ins.alu_sw),
    .result (alu_res)
  );

  mem_align u_align (
    .ls        (ins.ls),
    .offset    (alu_res[2:0]),
    .store_val (ins.val_c),
    .rdata     (mem_resp.rdata),
    .wdata     (st_wdata),
    .wstrb     (st_wstrb),
    .load_val  (ld_val)
  );

  // bus drive, address is always the alu result
  assign mem_req.arvalid = (state == load_req);
  assign mem_req.araddr = alu_res;
  assign mem_req.arsize = {1'b0, ins.ls[1:0]};
  assign mem_req.rready = (state == load_resp);
  assign mem_req.awvalid = (state == store_req) | (state == store_addr);
  assign mem_req.awaddr = alu_res;
  assign mem_req.awsize = {1'b0, ins.ls[1:0]};
  assign mem_req.wvalid = (state == store_req) | (state == store_data);
  assign mem_req.wdata = st_wdata;
  assign mem_req.wstrb = st_wstrb;
  assign mem_req.bready = (state == store_resp);

  always_comb begin
    case (ins.goto)
      GOTO_NONE: take = 1'b0;
      GOTO_PC_REL, GOTO_REG_REL, GOTO_REG: take = 1'b1;
      GOTO_BNEZ: take = |alu_res;
      GOTO_BEQZ: take = ~|alu_res;
      default: take = 1'b0;
    endcase
  end

  assign dnpc_base = ((ins.goto == GOTO_REG_REL) | (ins.goto == GOTO_REG)) ? ins.val_a : ins.pc;
  assign dnpc_offs = (ins.goto == GOTO_REG) ? '0 : ins.val_c;
  assign dnpc = dnpc_base + dnpc_offs;

  assign jump_en = result_valid & take;
  assign jump_dnpc = {dnpc[31:1], 1'b0};

  // write-back record
  assign result.gpr_wen = |ins.rd;
  assign result.gpr_waddr = ins.rd;
  assign result.gpr_wdata = ins.ls[3] ? load_val_q : (ins.rd_src ? ins.val_a : alu_res);
  assign result.csr_wen = (ins.csrw != CSRW_NONE);
  assign result.csr_waddr = (ins.csrw == CSRW_BREAK) ? '0 : ins.val_c[11:0];
  assign result.csr_wdata = (ins.csrw == CSRW_ALU) ? alu_res : ins.val_b;

endmodule

/* design/data_ram.sv */
`timescale 1ns/1ns

module data_ram
  import exu_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  mem_req_t  mem_req,
  output mem_resp_t mem_resp
);

  dword_t mem [RAM_WORDS];

  logic ar_ready;
  logic r_valid;
  logic aw_pending;
  logic w_pending;
  logic b_valid;

  dword_t rdata_q;
  ram_idx_t aw_idx_q;
  dword_t wdata_q;
  strb_t wstrb_q;

  logic ar_fire;
  logic aw_fire;
  logic w_fire;
  logic wr_go;
  ram_idx_t wr_idx;
  dword_t wr_data;
  strb_t wr_strb;

  assign mem_resp.arready = ar_ready;
  assign mem_resp.rvalid = r_valid;
  assign mem_resp.rdata = rdata_q;
  // address taken at once, data one cycle after the address
  assign mem_resp.awready = mem_req.awvalid & ~aw_pending & ~b_valid;
  assign mem_resp.wready = aw_pending & ~w_pending;
  assign mem_resp.bvalid = b_valid;

  assign ar_fire = mem_req.arvalid & ar_ready;
  assign aw_fire = mem_req.awvalid & mem_resp.awready;
  assign w_fire = mem_req.wvalid & mem_resp.wready;

  // write once both halves are in, either held or arriving now
  assign wr_go = (aw_pending | aw_fire) & (w_pending | w_fire) & ~b_valid;
  assign wr_idx = aw_pending ? aw_idx_q : mem_req.awaddr[RAM_IDX_W+2:3];
  assign wr_data = w_pending ? wdata_q : mem_req.wdata;
  assign wr_strb = w_pending ? wstrb_q : mem_req.wstrb;

  always_ff @(posedge clock) begin
    if (reset) begin
      ar_ready <= 1'b0;
      r_valid <= 1'b0;
      aw_pending <= 1'b0;
      w_pending <= 1'b0;
      b_valid <= 1'b0;
    end else begin
      if (ar_fire) begin
        ar_ready <= 1'b0;
        r_valid <= 1'b1;
      end else if (mem_req.arvalid & ~r_valid) begin
        ar_ready <= 1'b1;
      end
      if (r_valid & mem_req.rready) r_valid <= 1'b0;

      if (wr_go) begin
        aw_pending <= 1'b0;
        w_pending <= 1'b0;
        b_valid <= 1'b1;
      end else begin
        if (aw_fire) aw_pending <= 1'b1;
        if (w_fire) w_pending <= 1'b1;
      end
      if (b_valid & mem_req.bready) b_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (ar_fire) rdata_q <= mem[mem_req.araddr[RAM_IDX_W+2:3]];
    if (aw_fire) aw_idx_q <= mem_req.awaddr[RAM_IDX_W+2:3];
    if (w_fire) begin
      wdata_q <= mem_req.wdata;
      wstrb_q <= mem_req.wstrb;
    end
    if (wr_go) begin
      for (int i = 0; i < 8; i++) begin
        if (wr_strb[i]) mem[wr_idx][i*8 +: 8] <= wr_data[i*8 +: 8];
      end
    end
  end

endmodule

/* design/exec_top.sv */
`timescale 1ns/1ns

module exec_top
  import exu_pkg::*;
(
  input  logic   clock,
  input  logic   reset,
  input  issue_t issue,
  input  logic   issue_valid,
  output logic   issue_ready,
  output wb_t    result,
  output logic   result_valid,
  input  logic   result_ready,
  output logic   jump_en,
  output word_t  jump_dnpc
);

  mem_req_t mem_req;
  mem_resp_t mem_resp;

  exu u_exu (
    .clock        (clock),
    .reset        (reset),
    .issue        (issue),
    .issue_valid  (issue_valid),
    .issue_ready  (issue_ready),
    .result       (result),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .jump_en      (jump_en),
    .jump_dnpc    (jump_dnpc),
    .mem_req      (mem_req),
    .mem_resp     (mem_resp)
  );

  // single-port data store on the split bus
  data_ram u_ram (
    .clock    (clock),
    .reset    (reset),
    .mem_req  (mem_req),
    .mem_resp (mem_resp)
  );

endmodule

/* verification/exec_props.sv */
`timescale 1ns/1ns

module exec_props
  import exu_pkg::*;
(
  input logic      clock,
  input logic      reset,
  input issue_t    issue,
  input logic      issue_valid,
  input logic      issue_ready,
  input wb_t       result,
  input logic      result_valid,
  input logic      result_ready,
  input logic      jump_en,
  input word_t     jump_dnpc,
  input mem_req_t  mem_req,
  input mem_resp_t mem_resp
);

  int violations;

  ar_held: assert property (@(posedge clock) disable iff (reset)
    mem_req.arvalid && !mem_resp.arready |=>
      mem_req.arvalid && $stable(mem_req.araddr) && $stable(mem_req.arsize))
  else begin
    violations++;
    $error("arvalid dropped or read address changed before arready");
  end

  aw_held: assert property (@(posedge clock) disable iff (reset)
    mem_req.awvalid && !mem_resp.awready |=> mem_req.awvalid && $stable(mem_req.awaddr))
  else begin
    violations++;
    $error("awvalid dropped or write address changed before awready");
  end

  w_held: assert property (@(posedge clock) disable iff (reset)
    mem_req.wvalid && !mem_resp.wready |=>
      mem_req.wvalid && $stable(mem_req.wdata) && $stable(mem_req.wstrb))
  else begin
    violations++;
    $error("wvalid dropped or write data changed before wready");
  end

  r_held: assert property (@(posedge clock) disable iff (reset)
    mem_resp.rvalid && !mem_req.rready |=> mem_resp.rvalid && $stable(mem_resp.rdata))
  else begin
    violations++;
    $error("rvalid dropped or read data changed before rready");
  end

  b_held: assert property (@(posedge clock) disable iff (reset)
    mem_resp.bvalid && !mem_req.bready |=> mem_resp.bvalid)
  else begin
    violations++;
    $error("bvalid dropped before bready");
  end

  // result side back-pressure
  result_held: assert property (@(posedge clock) disable iff (reset)
    result_valid && !result_ready |=>
      result_valid && $stable(result) && $stable(jump_en) && $stable(jump_dnpc))
  else begin
    violations++;
    $error("result changed or withdrawn while result_ready was low");
  end

  quiet_after_reset: assert property (@(posedge clock)
    reset |=> !(mem_req.arvalid || mem_req.awvalid || mem_req.wvalid ||
                mem_resp.rvalid || mem_resp.bvalid))
  else begin
    violations++;
    $error("bus valid raised in the cycle after reset");
  end

  mem_busy: assert property (@(posedge clock) disable iff (reset)
    issue_valid && issue_ready && (issue.ls != '0) |=> !issue_ready)
  else begin
    violations++;
    $error("issue_ready high right after a memory instruction was accepted");
  end

endmodule

bind exu exec_props u_props (
  .clock        (clock),
  .reset        (reset),
  .issue        (issue),
  .issue_valid  (issue_valid),
  .issue_ready  (issue_ready),
  .result       (result),
  .result_valid (result_valid),
  .result_ready (result_ready),
  .jump_en      (jump_en),
  .jump_dnpc    (jump_dnpc),
  .mem_req      (mem_req),
  .mem_resp     (mem_resp)
);

/* verification/exec_tb.sv */
`timescale 1ns/1ns

module exec_tb
  import exu_pkg::*;
();

  // about 200 instructions at up to 8 cycles plus stalls and margin
  localparam int CYCLE_LIMIT = 4000;

  logic clock = 1'b0;
  logic reset;
  issue_t issue;
  logic issue_valid;
  logic issue_ready;
  wb_t result;
  logic result_valid;
  logic result_ready;
  logic jump_en;
  word_t jump_dnpc;

  int seed;
  int stall_seed;
  int stall_left;
  logic bp_on;
  int cycles;
  int checks;
  int errors;

  logic [7:0] ref_mem [2048];
  word_t word_addrs[$];

  // expected results in issue order
  string exp_test[$];
  wb_t exp_wb[$];
  logic exp_jen[$];
  word_t exp_dnpc[$];

  exec_top UUT (
    .clock        (clock),
    .reset        (reset),
    .issue        (issue),
    .issue_valid  (issue_valid),
    .issue_ready  (issue_ready),
    .result       (result),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .jump_en      (jump_en),
    .jump_dnpc    (jump_dnpc)
  );

  always #2 clock = ~clock;

  function automatic word_t rand_word();
    return $random(seed);
  endfunction

  function automatic logic coin();
    word_t w;
    w = rand_word();
    return w[0];
  endfunction

  function automatic word_t golden_alu(word_t a, word_t b, alu_funct_t fn, logic alt);
    case (fn)
      FN_ADD: return alt ? a - b : a + b;
      FN_SLL: return a << b[4:0];
      FN_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      FN_SLTU: return (a < b) ? 32'd1 : 32'd0;
      FN_XOR: return a ^ b;
      FN_SR: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      FN_OR: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic int size_bytes(logic [1:0] size);
    case (size)
      LS_BYTE: return 1;
      LS_HALF: return 2;
      default: return 4;
    endcase
  endfunction

  function automatic word_t read_ref_mem(word_t addr, ls_t ls);
    int n;
    word_t v;
    n = size_bytes(ls[1:0]);
    v = '0;
    for (int i = 0; i < n; i++) v[8*i +: 8] = ref_mem[addr[10:0] + i];
    if (ls[2] && n == 1) v[31:8] = {24{v[7]}};
    if (ls[2] && n == 2) v[31:16] = {16{v[15]}};
    return v;
  endfunction

  function automatic void write_ref_mem(word_t addr, ls_t ls, word_t data);
    for (int i = 0; i < size_bytes(ls[1:0]); i++) ref_mem[addr[10:0] + i] = data[8*i +: 8];
  endfunction

  function automatic issue_t random_issue();
    issue_t ins;
    ins.pc = rand_word() & ~32'h3;
    ins.val_a = rand_word();
    ins.val_b = rand_word();
    ins.val_c = rand_word();
    ins.alu_src = 1'b0;
    ins.alu_funct = FN_ADD;
    ins.alu_sw = 1'b0;
    ins.rd = reg_addr_t'(rand_word());
    ins.rd_src = 1'b0;
    ins.ls = '0;
    ins.goto = GOTO_NONE;
    ins.csrw = CSRW_NONE;
    return ins;
  endfunction

  // address arrives as val_a + val_b
  function automatic issue_t mem_issue(word_t addr, ls_t ls);
    issue_t ins;
    ins = random_issue();
    ins.val_b = addr - ins.val_a;
    ins.ls = ls;
    return ins;
  endfunction

  function automatic word_t pick_addr(logic [1:0] size);
    word_t base;
    word_t off;
    base = word_addrs[rand_word() % word_addrs.size()];
    case (size)
      LS_BYTE: off = rand_word() % 4;
      LS_HALF: off = (rand_word() % 2) * 2;
      default: off = 0;
    endcase
    return base + off;
  endfunction

  task automatic compare_field(input string test, input string field,
                               input word_t exp, input word_t act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("error %s %s: expected %h, actual %h", test, field, exp, act);
    end
  endtask

  task automatic send(input issue_t ins, input string test);
    word_t alu_val;
    word_t ld_val;
    word_t tgt;
    logic jen;
    wb_t e;
    alu_val = golden_alu(ins.alu_src ? ins.pc : ins.val_a, ins.val_b, ins.alu_funct,
                         ins.alu_sw);
    ld_val = '0;
    if (ins.ls[3]) ld_val = read_ref_mem(alu_val, ins.ls);
    else if (ins.ls != '0) write_ref_mem(alu_val, ins.ls, ins.val_c);
    e.gpr_wen = (ins.rd != '0);
    e.gpr_waddr = ins.rd;
    if (ins.ls[3]) e.gpr_wdata = ld_val;
    else e.gpr_wdata = ins.rd_src ? ins.val_a : alu_val;
    e.csr_wen = (ins.csrw != CSRW_NONE);
    e.csr_waddr = (ins.csrw == CSRW_BREAK) ? 12'h000 : ins.val_c[11:0];
    e.csr_wdata = (ins.csrw == CSRW_ALU) ? alu_val : ins.val_b;
    jen = 1'b1;
    tgt = ins.pc + ins.val_c;
    case (ins.goto)
      GOTO_PC_REL: ;
      GOTO_REG_REL: tgt = ins.val_a + ins.val_c;
      GOTO_REG: tgt = ins.val_a;
      GOTO_BNEZ: jen = (alu_val != 0);
      GOTO_BEQZ: jen = (alu_val == 0);
      default: jen = 1'b0;
    endcase
    tgt[0] = 1'b0;
    exp_test.push_back(test);
    exp_wb.push_back(e);
    exp_jen.push_back(jen);
    exp_dnpc.push_back(tgt);
    issue = ins;
    issue_valid = 1'b1;
    @(negedge clock);
    while (!issue_ready) @(negedge clock);
    @(posedge clock);
    #1;
    issue_valid = 1'b0;
  endtask

  task automatic alu_instr(input int code);
    issue_t ins;
    ins = random_issue();
    ins.alu_funct = alu_funct_t'(code % 8);
    ins.alu_sw = (code >= 8);
    ins.alu_src = coin();
    ins.rd = ins.rd | 5'd1;
    send(ins, "alu");
  endtask

  // ls bit 2 is free for stores and keeps a byte store nonzero
  task automatic store_instr(input logic [1:0] size);
    word_t addr;
    if (size == LS_WORD) begin
      addr = (rand_word() % 512) * 4;
      word_addrs.push_back(addr);
    end else begin
      addr = pick_addr(size);
    end
    send(mem_issue(addr, {2'b01, size}), "store");
  endtask

  task automatic load_instr(input logic [1:0] size, input logic sign);
    send(mem_issue(pick_addr(size), {1'b1, sign, size}), "load");
  endtask

  // equal operands make the xor result zero
  task automatic jump_instr(input int i);
    issue_t ins;
    ins = random_issue();
    ins.goto = goto_t'(i % 6);
    ins.alu_funct = FN_XOR;
    if ((i / 6) % 2) ins.val_b = ins.val_a;
    send(ins, "jump");
  endtask

  task automatic csr_instr(input int i);
    issue_t ins;
    ins = random_issue();
    ins.csrw = csrw_t'(i % 4);
    ins.alu_funct = alu_funct_t'(rand_word());
    send(ins, "csr");
  endtask

  always @(negedge clock) begin
    string test;
    wb_t e;
    logic jen;
    word_t dnpc;
    if (!reset && !result_valid) begin
      assert (!jump_en) else begin
        errors++;
        $display("jump_en is high while no result is offered");
      end
    end
    if (!reset && result_valid && result_ready) begin
      if (exp_test.size() == 0) begin
        errors++;
        $display("a result came out with no instruction outstanding");
      end else begin
        test = exp_test.pop_front();
        e = exp_wb.pop_front();
        jen = exp_jen.pop_front();
        dnpc = exp_dnpc.pop_front();
        compare_field(test, "gpr_wen", e.gpr_wen, result.gpr_wen);
        compare_field(test, "gpr_waddr", e.gpr_waddr, result.gpr_waddr);
        compare_field(test, "gpr_wdata", e.gpr_wdata, result.gpr_wdata);
        compare_field(test, "csr_wen", e.csr_wen, result.csr_wen);
        if (e.csr_wen) begin
          compare_field(test, "csr_waddr", e.csr_waddr, result.csr_waddr);
          compare_field(test, "csr_wdata", e.csr_wdata, result.csr_wdata);
        end
        compare_field(test, "jump_en", jen, jump_en);
        if (jen) compare_field(test, "jump_dnpc", dnpc, jump_dnpc);
      end
    end
  end

  // random stalls of 0 to 5 cycles on the result side
  always @(posedge clock) begin
    #1;
    if (!bp_on) begin
      result_ready = 1'b1;
    end else if (stall_left > 0) begin
      result_ready = 1'b0;
      stall_left--;
    end else begin
      result_ready = 1'b1;
      stall_left = {$random(stall_seed)} % 6;
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles with %0d results still outstanding",
               cycles, exp_test.size());
      $display("checks %0d, errors %0d, protocol errors %0d",
               checks, errors, UUT.u_exu.u_props.violations);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial begin
    seed = 32'h2f81;
    stall_seed = 32'h2f81;
    stall_left = 0;
    bp_on = 1'b0;
    cycles = 0;
    checks = 0;
    errors = 0;
    reset = 1'b1;
    issue = '0;
    issue_valid = 1'b0;
    result_ready = 1'b1;
    repeat (5) @(posedge clock);
    #1;
    reset = 1'b0;

    for (int i = 0; i < 60; i++) alu_instr(i % 16);
    for (int i = 0; i < 8; i++) begin
      issue = random_issue();
      issue.rd_src = (i < 4);
      if (i >= 4) issue.rd = '0;
      send(issue, (i < 4) ? "rd_src" : "rd_zero");
    end

    for (int i = 0; i < 12; i++) store_instr(LS_WORD);
    for (int i = 0; i < 12; i++) store_instr((i % 2) ? LS_HALF : LS_BYTE);
    for (int i = 0; i < 24; i++) load_instr(2'(i % 3), (i / 3) % 2);

    for (int i = 0; i < 24; i++) jump_instr(i);
    for (int i = 0; i < 8; i++) csr_instr(i);

    bp_on = 1'b1;
    for (int i = 0; i < 40; i++) begin
      case (i % 5)
        0: alu_instr(rand_word() % 16);
        1: store_instr(2'(rand_word() % 3));
        2: load_instr(2'(rand_word() % 3), coin());
        3: jump_instr(i);
        default: csr_instr(i);
      endcase
    end

    while (exp_test.size() != 0) @(posedge clock);
    repeat (3) @(posedge clock);
    $display("checks %0d, errors %0d, protocol errors %0d",
             checks, errors, UUT.u_exu.u_props.violations);
    if (errors == 0 && UUT.u_exu.u_props.violations == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* all.f */
design/exu_pkg.sv
design/alu.sv
design/mem_align.sv
design/exu.sv
design/data_ram.sv
design/exec_top.sv
verification/exec_props.sv
verification/exec_tb.sv
